//--- src.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/pipe_pkg.sv
verilog/ex_ctrl_if.sv
verilog/alu.sv
verilog/forward_unit.sv
verilog/id_ex_reg.sv
verilog/execute.sv
verilog/ex_mem_wb_reg.sv
verilog/exec_pipe_top.sv
bench/exec_pipe_tb.sv

//--- Makefile
# Verilator build of the execute pipeline testbench

TOP       ?= exec_pipe_tb
SRC_F     ?= src.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(SRC_F) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^>>> PASS$$"

clean:
	rm -rf obj_dir

//--- bench/exec_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module exec_pipe_tb;
    import alu_pkg::*;

    typedef struct packed {
        alu_op_t            op;
        logic               alu_src;
        logic               op1_pc;
        branch_cond_t       f3;
        logic               jump;
        logic               branch;
        logic               jalr;
        logic               reg_write;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   imm;
    } instr_t;

    logic               clk = 1'b0;
    logic               reset;
    logic               in_valid;
    instr_t             drv;  // decoded fields on the DUT inputs
    logic [`XLEN-1:0]   rd1;
    logic [`XLEN-1:0]   rd2;
    logic               pc_src;
    logic [`XLEN-1:0]   pc_target;
    logic               mem_valid;
    logic [`REG_AW-1:0] mem_rd;
    logic [`XLEN-1:0]   mem_alu_result;
    logic [`XLEN-1:0]   mem_write_data;
    logic               wb_valid;
    logic               wb_reg_write;
    logic [`REG_AW-1:0] wb_rd;
    logic [`XLEN-1:0]   wb_result;

    // stimulus and expected columns, one entry per table row
    instr_t             rows[$];
    string              names[$];
    logic [`XLEN-1:0]   rd1_tab[$];
    logic [`XLEN-1:0]   rd2_tab[$];
    logic [`XLEN-1:0]   exp_result[$];
    logic [`XLEN-1:0]   exp_target[$];
    logic [`XLEN-1:0]   exp_wdata[$];
    logic               exp_valid[$];
    logic               exp_pc_src[$];

    int checks = 0;
    int errors = 0;
    int cycles = 0;
    int max_cycles = 1000;

    exec_pipe_top dut0 (
        .clk(clk), .reset(reset), .in_valid(in_valid), .alu_ctrl(drv.op),
        .alu_src(drv.alu_src), .op1_pc(drv.op1_pc), .funct3(drv.f3), .jump(drv.jump),
        .branch(drv.branch), .jalr(drv.jalr), .reg_write(drv.reg_write),
        .rs1(drv.rs1), .rs2(drv.rs2), .rd(drv.rd), .rd1(rd1), .rd2(rd2),
        .pc(drv.pc), .imm_ext(drv.imm), .pc_src(pc_src), .pc_target(pc_target),
        .mem_valid(mem_valid), .mem_rd(mem_rd), .mem_alu_result(mem_alu_result),
        .mem_write_data(mem_write_data), .wb_valid(wb_valid),
        .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_result(wb_result)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: pipeline run did not end within %0d cycles", max_cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    // RV32I semantics of each operation
    function automatic logic [`XLEN-1:0] alu_model(input alu_op_t op,
                                                   input logic [`XLEN-1:0] a, b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return $unsigned($signed(a) >>> sh);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return b;  // lui
        endcase
    endfunction

    function automatic logic cond_holds(input branch_cond_t f3, input logic [`XLEN-1:0] a, b);
        case (f3)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic add_row(input string name, input alu_op_t op, input logic alu_src, op1_pc,
                           input branch_cond_t f3, input logic jump, branch, jalr, reg_write,
                           input logic [4:0] rs1, rs2, rd, input logic [`XLEN-1:0] imm);
        instr_t r;
        r = '{op, alu_src, op1_pc, f3, jump, branch, jalr, reg_write, rs1, rs2, rd, 32'd0, imm};
        r.pc = 32'h0000_0100 + 32'(rows.size()) * 32'd4;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic rr_instr(input string name, input alu_op_t op, input logic [4:0] rd, rs1, rs2);
        add_row(name, op, 1'b0, 1'b0, BR_BEQ, 1'b0, 1'b0, 1'b0, 1'b1, rs1, rs2, rd, '0);
    endtask

    task automatic imm_instr(input string name, input alu_op_t op, input logic [4:0] rd, rs1,
                             input logic [`XLEN-1:0] imm);
        add_row(name, op, 1'b1, 1'b0, BR_BEQ, 1'b0, 1'b0, 1'b0, 1'b1, rs1, 5'd0, rd, imm);
    endtask

    task automatic branch_instr(input string name, input branch_cond_t f3,
                                input logic [4:0] rs1, rs2, input logic [`XLEN-1:0] imm);
        add_row(name, ALU_SUB, 1'b0, 1'b0, f3, 1'b0, 1'b1, 1'b0, 1'b0, rs1, rs2, 5'd0, imm);
    endtask

    task automatic build_table();
        logic [3:0] k;
        add_row("lui", ALU_PASS_B, 1, 0, BR_BEQ, 0, 0, 0, 1, 0, 0, 1, 32'h8000_0000);
        imm_instr("addi_neg", ALU_ADD, 2, 0, 32'hFFFF_FFFB);
        imm_instr("addi_pos", ALU_ADD, 3, 0, 32'd7);
        rr_instr("add_fwd_mem_wb", ALU_ADD, 4, 2, 3);
        rr_instr("sub", ALU_SUB, 5, 3, 2);
        rr_instr("sll", ALU_SLL, 6, 3, 3);
        rr_instr("slt", ALU_SLT, 7, 2, 3);
        rr_instr("sltu", ALU_SLTU, 8, 2, 3);
        rr_instr("xor", ALU_XOR, 9, 1, 2);
        rr_instr("srl", ALU_SRL, 10, 1, 3);
        rr_instr("sra", ALU_SRA, 11, 1, 3);
        rr_instr("or", ALU_OR, 12, 2, 3);
        rr_instr("and", ALU_AND, 13, 2, 3);
        rr_instr("sll_27", ALU_SLL, 14, 3, 2);
        imm_instr("srai_31", ALU_SRA, 15, 1, 32'd31);
        imm_instr("slti", ALU_SLT, 16, 2, 32'hFFFF_FFFA);
        imm_instr("old_x20", ALU_ADD, 20, 0, 32'd1);
        imm_instr("new_x20", ALU_ADD, 20, 0, 32'd2);
        rr_instr("newer_wins", ALU_ADD, 21, 20, 20);
        imm_instr("x0_write", ALU_ADD, 0, 3, 32'd99);
        rr_instr("x0_read", ALU_ADD, 22, 0, 3);
        branch_instr("beq_taken", BR_BEQ, 3, 3, 32'h40);
        imm_instr("flush_beq", ALU_ADD, 23, 0, 32'd55);
        branch_instr("beq_not", BR_BEQ, 2, 3, 32'h40);
        branch_instr("bne_not", BR_BNE, 3, 3, 32'h40);
        branch_instr("bne_taken", BR_BNE, 2, 3, 32'h44);
        imm_instr("flush_bne", ALU_ADD, 24, 0, 32'd66);
        branch_instr("blt_taken", BR_BLT, 2, 3, 32'h80);
        imm_instr("flush_blt", ALU_ADD, 24, 0, 32'd67);
        branch_instr("blt_not", BR_BLT, 3, 2, 32'h80);
        branch_instr("bge_not", BR_BGE, 2, 3, 32'h10);
        branch_instr("bge_taken", BR_BGE, 3, 2, 32'h18);
        imm_instr("flush_bge", ALU_ADD, 23, 0, 32'd68);
        branch_instr("bltu_not", BR_BLTU, 2, 3, 32'h10);
        branch_instr("bltu_taken", BR_BLTU, 3, 2, 32'h20);
        imm_instr("flush_bltu", ALU_ADD, 25, 0, 32'd69);
        branch_instr("bgeu_not", BR_BGEU, 3, 2, 32'h10);
        branch_instr("bgeu_taken", BR_BGEU, 2, 3, 32'hFFFF_FFF0);
        imm_instr("flush_bgeu", ALU_ADD, 25, 0, 32'd77);
        rr_instr("after_flush", ALU_ADD, 26, 25, 24);  // flushed writes never land
        add_row("jal", ALU_ADD, 1, 1, BR_BEQ, 1, 0, 0, 1, 0, 0, 28, 32'h0000_0200);
        imm_instr("flush_jal", ALU_ADD, 29, 0, 32'd5);
        rr_instr("use_link", ALU_ADD, 29, 28, 0);
        add_row("jalr", ALU_ADD, 1, 0, BR_BEQ, 1, 0, 1, 1, 3, 0, 30, 32'd8);
        imm_instr("flush_jalr", ALU_ADD, 31, 0, 32'd6);
        add_row("auipc", ALU_ADD, 1, 1, BR_BEQ, 0, 0, 0, 1, 0, 0, 31, 32'h0000_1000);
        for (int n = 0; n < 8; n++) begin
            k = 4'($urandom_range(9, 0));
            if (n % 2 == 0) begin
                rr_instr($sformatf("random_%0d", n), alu_op_t'(k), 5'($urandom_range(31, 16)),
                         5'($urandom_range(31, 16)), 5'($urandom_range(31, 16)));
            end else begin
                imm_instr($sformatf("random_%0d", n), alu_op_t'(k), 5'($urandom_range(31, 16)),
                          5'($urandom_range(31, 16)), $urandom());
            end
        end
    endtask

    // register file read in decode only sees writes from three slots back
    task automatic build_expected();
        logic [`XLEN-1:0] cur [32];
        logic [`XLEN-1:0] stale [32];
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] alu_out;
        instr_t           r;
        logic             live;
        cur[0] = '0;
        for (int k = 1; k < 32; k++) begin
            cur[k] = $urandom();
        end
        stale = cur;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (i >= 3 && exp_valid[i-3] && rows[i-3].reg_write && rows[i-3].rd != '0) begin
                stale[rows[i-3].rd] = exp_result[i-3];
            end
            live    = !(i > 0 && exp_pc_src[i-1]);
            a       = r.op1_pc ? r.pc : cur[r.rs1];
            b       = r.alu_src ? r.imm : cur[r.rs2];
            alu_out = alu_model(r.op, a, b);
            rd1_tab.push_back(stale[r.rs1]);
            rd2_tab.push_back(stale[r.rs2]);
            exp_valid.push_back(live);
            exp_result.push_back(r.jump ? r.pc + 32'd4 : alu_out);
            exp_target.push_back(r.jalr ? {alu_out[`XLEN-1:1], 1'b0} : r.pc + r.imm);
            exp_wdata.push_back(cur[r.rs2]);  // store data is the up to date rs2
            exp_pc_src.push_back(live && (r.jump || (r.branch && cond_holds(r.f3, a, b))));
            if (live && r.reg_write && r.rd != '0) begin
                cur[r.rd] = exp_result[i];
            end
        end
    endtask

    task automatic compare_word(input string name, input string what,
                                input logic [`XLEN-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input string what, input logic exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_mem(input int i);
        compare_bit(names[i], "mem_valid", exp_valid[i], mem_valid);
        if (exp_valid[i]) begin
            compare_word(names[i], "mem_rd", 32'(rows[i].rd), 32'(mem_rd));
            compare_word(names[i], "mem_alu_result", exp_result[i], mem_alu_result);
            compare_word(names[i], "mem_write_data", exp_wdata[i], mem_write_data);
        end
    endtask

    task automatic check_wb(input int i);
        compare_bit(names[i], "wb_valid", exp_valid[i], wb_valid);
        if (exp_valid[i]) begin
            compare_bit(names[i], "wb_reg_write", rows[i].reg_write, wb_reg_write);
            compare_word(names[i], "wb_result", exp_result[i], wb_result);
            compare_word(names[i], "wb_rd", 32'(rows[i].rd), 32'(wb_rd));
        end
    endtask

    initial begin
        void'($urandom(32'h8678));
        reset    = 1'b1;
        in_valid = 1'b0;
        drv      = '0;
        rd1      = '0;
        rd2      = '0;
        build_table();
        build_expected();
        max_cycles = rows.size() + 20;
        repeat (5) @(posedge clk);
        #0.5;
        reset = 1'b0;
        compare_bit("reset", "pc_src", 1'b0, pc_src);
        compare_bit("reset", "mem_valid", 1'b0, mem_valid);
        compare_bit("reset", "wb_valid", 1'b0, wb_valid);
        for (int t = 0; t < rows.size() + 3; t++) begin
            if (t >= 1 && t <= rows.size()) begin
                compare_bit(names[t-1], "pc_src", exp_pc_src[t-1], pc_src);
                if (exp_valid[t-1] && (rows[t-1].branch || rows[t-1].jump)) begin
                    compare_word(names[t-1], "pc_target", exp_target[t-1], pc_target);
                end
            end
            if (t >= 2 && t < rows.size() + 2) begin
                check_mem(t - 2);
            end
            if (t >= 3) begin
                check_wb(t - 3);
            end
            if (t < rows.size()) begin
                drv      = rows[t];
                rd1      = rd1_tab[t];
                rd2      = rd2_tab[t];
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
            @(posedge clk);
            #0.5;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/exec_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module exec_pipe_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  alu_pkg::alu_op_t      alu_ctrl,
    input  logic                  alu_src,
    input  logic                  op1_pc,
    input  alu_pkg::branch_cond_t funct3,
    input  logic                  jump,
    input  logic                  branch,
    input  logic                  jalr,
    input  logic                  reg_write,
    input  logic [`REG_AW-1:0]    rs1,
    input  logic [`REG_AW-1:0]    rs2,
    input  logic [`REG_AW-1:0]    rd,
    input  logic [`XLEN-1:0]      rd1,
    input  logic [`XLEN-1:0]      rd2,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      imm_ext,
    output logic                  pc_src,
    output logic [`XLEN-1:0]      pc_target,
    output logic                  mem_valid,
    output logic [`REG_AW-1:0]    mem_rd,
    output logic [`XLEN-1:0]      mem_alu_result,
    output logic [`XLEN-1:0]      mem_write_data,
    output logic                  wb_valid,
    output logic                  wb_reg_write,
    output logic [`REG_AW-1:0]    wb_rd,
    output logic [`XLEN-1:0]      wb_result
);
    import pipe_pkg::*;

    ex_mem_t          ex_mem;
    mem_wb_t          mem_wb;
    fwd_sel_t         fwd_rs1;
    fwd_sel_t         fwd_rs2;
    logic [`XLEN-1:0] alu_result_e;
    logic [`XLEN-1:0] write_data_e;

    ex_ctrl_if ex_if (.clk(clk), .reset(reset));

    id_ex_reg u_id_ex (
        .clk(clk), .reset(reset), .flush(pc_src),  // kill the slot behind a taken transfer
        .in_valid(in_valid), .alu_ctrl(alu_ctrl), .alu_src(alu_src), .op1_pc(op1_pc),
        .funct3(funct3), .jump(jump), .branch(branch), .jalr(jalr),
        .reg_write(reg_write), .rs1(rs1), .rs2(rs2), .rd(rd),
        .rd1(rd1), .rd2(rd2), .pc(pc), .imm_ext(imm_ext), .ex(ex_if.stage)
    );

    forward_unit u_fwd (
        .ex(ex_if.exec), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2)
    );

    execute u_execute (
        .ex(ex_if.exec), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
        .alu_result_m(ex_mem.alu_result), .result_w(mem_wb.result),
        .pc_src(pc_src), .alu_result(alu_result_e), .write_data(write_data_e),
        .pc_target(pc_target)
    );

    ex_mem_wb_reg u_ex_mem_wb (
        .clk(clk), .reset(reset), .ex(ex_if.exec),
        .alu_result(alu_result_e), .write_data(write_data_e),
        .ex_mem(ex_mem), .mem_wb(mem_wb)
    );

    assign mem_valid      = ex_mem.valid;
    assign mem_rd         = ex_mem.rd;
    assign mem_alu_result = ex_mem.alu_result;
    assign mem_write_data = ex_mem.write_data;
    assign wb_valid       = mem_wb.valid;
    assign wb_reg_write   = mem_wb.reg_write;
    assign wb_rd          = mem_wb.rd;
    assign wb_result      = mem_wb.result;

endmodule

`default_nettype wire

//--- verilog/ex_mem_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module ex_mem_wb_reg (
    input  logic              clk,
    input  logic              reset,
    ex_ctrl_if.exec           ex,
    input  logic [`XLEN-1:0]  alu_result,
    input  logic [`XLEN-1:0]  write_data,
    output pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::mem_wb_t mem_wb
);
    import pipe_pkg::*;

    logic [`XLEN-1:0] link_addr;

    assign link_addr = ex.pc + 'd4;  // return address for jal / jalr

    always_ff @(posedge clk) begin
        ex_mem.rd         <= ex.rd;
        ex_mem.alu_result <= ex.jump ? link_addr : alu_result;
        ex_mem.write_data <= write_data;
        mem_wb.rd         <= ex_mem.rd;
        mem_wb.result     <= ex_mem.alu_result;  // no data memory
        if (reset) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            mem_wb.valid     <= 1'b0;
            mem_wb.reg_write <= 1'b0;
        end else begin
            ex_mem.valid     <= ex.valid;
            ex_mem.reg_write <= ex.valid & ex.reg_write;
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
        end
    end

endmodule

`default_nettype wire

//--- verilog/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module execute (
    ex_ctrl_if.exec            ex,
    input  pipe_pkg::fwd_sel_t fwd_rs1,
    input  pipe_pkg::fwd_sel_t fwd_rs2,
    input  logic [`XLEN-1:0]   alu_result_m,
    input  logic [`XLEN-1:0]   result_w,
    output logic               pc_src,
    output logic [`XLEN-1:0]   alu_result,
    output logic [`XLEN-1:0]   write_data,
    output logic [`XLEN-1:0]   pc_target
);
    import pipe_pkg::*;

    logic [`XLEN-1:0] fwd_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] pc_imm;
    logic             cond_true;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_t         sel,
        input logic [`XLEN-1:0] reg_val
    );
        logic [`XLEN-1:0] val;
        case (sel)
            FWD_REG: val = reg_val;
            FWD_WB:  val = result_w;
            FWD_MEM: val = alu_result_m;
            default: val = '0;
        endcase
        return val;
    endfunction

    assign fwd_a = fwd_mux(fwd_rs1, ex.rd1);
    assign fwd_b = fwd_mux(fwd_rs2, ex.rd2);

    assign src_a = ex.op1_pc ? ex.pc : fwd_a;       // auipc, jal
    assign src_b = ex.alu_src ? ex.imm_ext : fwd_b;

    alu u_alu (
        .op_a      (src_a),
        .op_b      (src_b),
        .alu_ctrl  (ex.alu_ctrl),
        .funct3    (ex.funct3),
        .result    (alu_result),
        .cond_true (cond_true)
    );

    assign pc_imm     = ex.pc + ex.imm_ext;
    assign pc_target  = ex.jalr ? {alu_result[`XLEN-1:1], 1'b0} : pc_imm;
    assign pc_src     = ex.valid & (ex.jump | (ex.branch & cond_true));
    assign write_data = fwd_b;  // store data, already forwarded

    // decode must never mark an instruction as both jump and branch
    a_jump_xor_branch: assert property (@(posedge ex.clk) disable iff (ex.reset)
        ex.valid |-> !(ex.jump && ex.branch));

endmodule

`default_nettype wire

//--- verilog/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module id_ex_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,     // taken branch or jump in EX
    input  logic                  in_valid,
    input  alu_pkg::alu_op_t      alu_ctrl,
    input  logic                  alu_src,
    input  logic                  op1_pc,
    input  alu_pkg::branch_cond_t funct3,
    input  logic                  jump,
    input  logic                  branch,
    input  logic                  jalr,
    input  logic                  reg_write,
    input  logic [`REG_AW-1:0]    rs1,
    input  logic [`REG_AW-1:0]    rs2,
    input  logic [`REG_AW-1:0]    rd,
    input  logic [`XLEN-1:0]      rd1,
    input  logic [`XLEN-1:0]      rd2,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      imm_ext,
    ex_ctrl_if.stage              ex
);

    // control bits, a flush leaves a bubble
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ex.valid     <= 1'b0;
            ex.reg_write <= 1'b0;
            ex.jump      <= 1'b0;
            ex.branch    <= 1'b0;
        end else begin
            ex.valid     <= in_valid;
            ex.reg_write <= in_valid & reg_write;
            ex.jump      <= in_valid & jump;
            ex.branch    <= in_valid & branch;
        end
    end

    always_ff @(posedge clk) begin
        ex.alu_ctrl <= alu_ctrl;
        ex.alu_src  <= alu_src;
        ex.op1_pc   <= op1_pc;
        ex.funct3   <= funct3;
        ex.jalr     <= jalr;
        ex.rs1      <= rs1;
        ex.rs2      <= rs2;
        ex.rd       <= rd;
        ex.rd1      <= rd1;
        ex.rd2      <= rd2;
        ex.pc       <= pc;
        ex.imm_ext  <= imm_ext;
    end

endmodule

`default_nettype wire

//--- verilog/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module forward_unit (
    ex_ctrl_if.exec           ex,
    input  pipe_pkg::ex_mem_t ex_mem,
    input  pipe_pkg::mem_wb_t mem_wb,
    output pipe_pkg::fwd_sel_t fwd_rs1,
    output pipe_pkg::fwd_sel_t fwd_rs2
);
    import pipe_pkg::*;

    // newer stage wins, x0 never forwarded
    function automatic fwd_sel_t pick_src(
        input logic [`REG_AW-1:0] rs,
        input ex_mem_t            m,
        input mem_wb_t            w
    );
        fwd_sel_t sel;
        sel = FWD_REG;
        if (m.valid && m.reg_write && m.rd != '0 && m.rd == rs) begin
            sel = FWD_MEM;
        end else if (w.valid && w.reg_write && w.rd != '0 && w.rd == rs) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_rs1 = pick_src(ex.rs1, ex_mem, mem_wb);
    assign fwd_rs2 = pick_src(ex.rs2, ex_mem, mem_wb);

    // a read of x0 always takes the register value
    a_x0_not_fwd: assert property (@(posedge ex.clk) disable iff (ex.reset)
        ex.valid |-> ((ex.rs1 != '0 || fwd_rs1 == FWD_REG) &&
                      (ex.rs2 != '0 || fwd_rs2 == FWD_REG)));

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module alu (
    input  logic [`XLEN-1:0]     op_a,
    input  logic [`XLEN-1:0]     op_b,
    input  alu_pkg::alu_op_t     alu_ctrl,
    input  alu_pkg::branch_cond_t funct3,
    output logic [`XLEN-1:0]     result,
    output logic                 cond_true
);
    import alu_pkg::*;

    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     eq;
    logic                     lt;
    logic                     ltu;

    assign shamt = op_b[$clog2(`XLEN)-1:0];
    assign eq    = (op_a == op_b);
    assign lt    = ($signed(op_a) < $signed(op_b));
    assign ltu   = (op_a < op_b);

    always_comb begin
        case (alu_ctrl)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt};
            ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, ltu};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $signed(op_a) >>> shamt;
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // branch compare runs on the same operands
    always_comb begin
        case (funct3)
            BR_BEQ:  cond_true = eq;
            BR_BNE:  cond_true = !eq;
            BR_BLT:  cond_true = lt;
            BR_BGE:  cond_true = !lt;
            BR_BLTU: cond_true = ltu;
            BR_BGEU: cond_true = !ltu;
            default: cond_true = 1'b0;
        endcase
    end

    always_comb begin
        if (!$isunknown(alu_ctrl)) begin
            a_legal_op: assert (alu_ctrl inside {[ALU_ADD:ALU_PASS_B]})
                else $error("alu: illegal alu_ctrl %0d", alu_ctrl);
        end
    end

endmodule

`default_nettype wire

//--- verilog/ex_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

interface ex_ctrl_if (
    input logic clk,
    input logic reset
);
    import alu_pkg::*;

    logic               valid;
    alu_op_t            alu_ctrl;
    logic               alu_src;    // operand b from immediate
    logic               op1_pc;     // operand a from pc
    branch_cond_t       funct3;
    logic               jump;
    logic               branch;
    logic               jalr;
    logic               reg_write;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   rd1;
    logic [`XLEN-1:0]   rd2;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   imm_ext;

    modport stage (
        output valid, alu_ctrl, alu_src, op1_pc, funct3, jump, branch, jalr,
        output reg_write, rs1, rs2, rd, rd1, rd2, pc, imm_ext
    );

    modport exec (
        input clk, reset,
        input valid, alu_ctrl, alu_src, op1_pc, funct3, jump, branch, jalr,
        input reg_write, rs1, rs2, rd, rd1, rd2, pc, imm_ext
    );

endinterface

`default_nettype wire

//--- verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    `include "rv_macros.svh"

    typedef enum logic [1:0] {
        FWD_REG  = 2'b00,  // value read in decode
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10,
        FWD_ZERO = 2'b11
    } fwd_sel_t;

    typedef struct packed {
        logic               valid;
        logic               reg_write;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   alu_result;  // pc+4 for jumps
        logic [`XLEN-1:0]   write_data;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic               reg_write;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   result;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // lui
    } alu_op_t;

    // same codes as the branch funct3 field
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_cond_t;

endpackage

`default_nettype wire

//--- verilog/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath width of the RV32I core
`define XLEN 32

// register number width, x0..x31
`define REG_AW 5

`endif
